// File: periph_subsys.f
+incdir+.
periph_pkg.sv
periph_decoder.sv
timer_unit.sv
irq_collector.sv
periph_subsys.sv
periph_subsys_assert.sv
tb_periph_subsys.sv

// File: tb_periph_subsys.sv
`timescale 1ns/100ps
`include "periph_cfg.svh"

module tb_periph_subsys
    import periph_pkg::*;
();

    localparam int NT = `PERIPH_NUM_TIMERS;
    localparam int IRQ_R = `PERIPH_IRQ_REGION;
    // Reset, six tests, then margin
    localparam int TIMEOUT_CYCLES = 16 + 100 + 160 + 60 + 120 + 160 + 120 + 200;

    logic      clk_i;
    logic      reset_i;
    logic      req_valid_i;
    logic      req_write_i;
    reg_addr_t req_addr_i;
    reg_data_t req_wdata_i;
    logic      rsp_valid_o;
    reg_data_t rsp_rdata_o;
    logic      rsp_error_o;
    logic      irq_o;

    // Reference model state
    reg_data_t   m_count [NT];
    reg_data_t   m_compare [NT];
    logic [NT-1:0] m_enable = '0;
    logic [NT-1:0] m_count_ok = '1;
    logic [NT-1:0] m_pending = '0;
    logic [NT-1:0] m_irq_en = '0;

    reg_data_t exp_data_q [$];
    logic      exp_err_q [$];
    logic      exp_chk_q [$];
    reg_data_t exp_d;
    logic      exp_c;
    reg_data_t last_rdata;
    int        edge_cnt = 0;
    int        rsp_cycle = 0;
    int        prev_rsp_cycle = 0;
    int        cycle_cnt = 0;
    int        n_pass = 0;
    int        n_fail = 0;
    int        test_fail = 0;
    logic [15:0] lfsr = 16'd30;

    periph_subsys UUT (.*);

    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    // Galois LFSR, one step per bit
    function automatic reg_data_t rand_bits(input int n);
        reg_data_t v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hb400) : (lfsr >> 1);
        end
        return v;
    endfunction

    function automatic reg_addr_t addr_of(input int region, input int offset);
        return reg_addr_t'((region << `PERIPH_REGION_LSB) | (offset << 2));
    endfunction

    // ----------------------------------------
    // Reference model
    // ----------------------------------------
    function automatic reg_data_t ref_response(input logic write, input reg_addr_t addr);
        int r;
        int o;
        r = addr[`PERIPH_REGION_LSB +: 4];
        o = addr[3:2];
        if (!(r < NT || r == IRQ_R)) return `PERIPH_ERR_DATA;
        if (write) return '0;
        if (r == IRQ_R) begin
            if (o == 0) return reg_data_t'(m_pending);
            if (o == 1) return reg_data_t'(m_irq_en);
            if (o == 2) begin
                for (int k = 0; k < NT; k++) begin
                    if (m_pending[k] && m_irq_en[k]) return reg_data_t'(k + 1);
                end
            end
            return '0;
        end
        if (o == 0) return reg_data_t'(m_enable[r]);
        if (o == 1) return m_count[r];
        if (o == 2) return m_compare[r];
        return '0;
    endfunction

    function automatic void model_update(input logic write, input reg_addr_t addr,
                                         input reg_data_t wdata);
        int r;
        int o;
        r = addr[`PERIPH_REGION_LSB +: 4];
        o = addr[3:2];
        if (r == IRQ_R && write && o == 1) begin
            m_irq_en = wdata[NT-1:0];
        end else if (r == IRQ_R && !write && o == 2) begin
            for (int k = 0; k < NT; k++) begin
                if (m_pending[k] && m_irq_en[k]) begin
                    m_pending[k] = 1'b0;
                    break;
                end
            end
        end else if (r < NT && write) begin
            if (o == 0) begin
                m_enable[r] = wdata[0];
                // A running count is no longer predictable
                if (wdata[0]) m_count_ok[r] = 1'b0;
            end
            if (o == 1) begin
                m_count[r] = wdata;
                m_count_ok[r] = 1'b1;
            end
            if (o == 2) m_compare[r] = wdata;
        end
    endfunction

    // ----------------------------------------
    // Checks and bus tasks
    // ----------------------------------------
    task automatic check_value(input string name, input reg_data_t exp, input reg_data_t act);
        assert (exp === act) begin
            n_pass++;
        end else begin
            n_fail++;
            test_fail++;
            $display("FAILED %s expected %h got %h", name, exp, act);
        end
    endtask

    task automatic check_true(input string what, input logic cond);
        assert (cond === 1'b1) begin
            n_pass++;
        end else begin
            n_fail++;
            test_fail++;
            $display("Check failed: %s", what);
        end
    endtask

    task automatic report_test(input string name);
        $display("Test %s: %0d errors", name, test_fail);
        test_fail = 0;
    endtask

    task automatic send_req(input logic write, input reg_addr_t addr, input reg_data_t wdata);
        int r;
        r = addr[`PERIPH_REGION_LSB +: 4];
        @(negedge clk_i);
        req_valid_i = 1'b1;
        req_write_i = write;
        req_addr_i  = addr;
        req_wdata_i = wdata;
        exp_data_q.push_back(ref_response(write, addr));
        exp_err_q.push_back(!(r < NT || r == IRQ_R));
        exp_chk_q.push_back(!(r < NT && !write && addr[3:2] == 2'd1 && !m_count_ok[r]));
        model_update(write, addr, wdata);
    endtask

    task automatic finish_reqs();
        @(negedge clk_i);
        req_valid_i = 1'b0;
        while (exp_data_q.size() != 0) begin
            @(negedge clk_i);
        end
    endtask

    task automatic access(input logic write, input int region, input int offset,
                          input reg_data_t wdata);
        send_req(write, addr_of(region, offset), wdata);
        finish_reqs();
    endtask

    // Response comparison
    always @(posedge clk_i) begin
        edge_cnt++;
        if (rsp_valid_o === 1'b1) begin
            if (exp_data_q.size() == 0) begin
                check_true("response arrived with no request outstanding", 1'b0);
            end else begin
                exp_d = exp_data_q.pop_front();
                exp_c = exp_chk_q.pop_front();
                if (exp_c) check_value("rsp_rdata_o", exp_d, rsp_rdata_o);
                check_value("rsp_error_o", reg_data_t'(exp_err_q.pop_front()),
                            reg_data_t'(rsp_error_o));
            end
            prev_rsp_cycle = rsp_cycle;
            rsp_cycle = edge_cnt;
            last_rdata = rsp_rdata_o;
        end
    end

    initial begin
        while (cycle_cnt < TIMEOUT_CYCLES) begin
            @(posedge clk_i);
            cycle_cnt++;
        end
        $display("Timeout after %0d cycles, a test did not complete", cycle_cnt);
        $display("Something failed");
        $finish;
    end

    // ----------------------------------------
    // Tests
    // ----------------------------------------
    initial begin
        reg_data_t a;
        reg_data_t b;
        reg_data_t cmp;
        int        t;
        int        wait_cyc;
        req_valid_i = 1'b0;
        req_write_i = 1'b0;
        req_addr_i  = '0;
        req_wdata_i = '0;
        reset_i     = 1'b1;
        for (int i = 0; i < NT; i++) begin
            m_count[i] = '0;
            m_compare[i] = '0;
        end
        repeat (16) @(posedge clk_i);
        @(negedge clk_i);
        reset_i = 1'b0;

        check_true("irq_o not low after reset", irq_o == 1'b0);
        check_true("rsp_valid_o not low after reset", rsp_valid_o == 1'b0);
        for (int i = 0; i < NT; i++) begin
            for (int o = 0; o < 3; o++) access(1'b0, i, o, '0);
        end
        access(1'b0, IRQ_R, 0, '0);
        access(1'b0, IRQ_R, 1, '0);
        report_test("1 reset state");

        for (int i = 0; i < NT; i++) begin
            access(1'b1, i, 2, rand_bits(32));
            access(1'b1, i, 1, rand_bits(32));
            access(1'b0, i, 2, '0);
            access(1'b0, i, 1, '0);
        end
        send_req(1'b1, addr_of(0, 2), rand_bits(32));
        send_req(1'b0, addr_of(0, 2), '0);
        finish_reqs();
        check_true("back-to-back responses not in consecutive cycles",
                   rsp_cycle - prev_rsp_cycle == 1);
        report_test("2 register readback");

        t = 4 + int'(rand_bits(3));
        access(1'b0, t, 1, '0);
        access(1'b1, t, 2, rand_bits(32));
        access(1'b1, IRQ_R, 3, rand_bits(32));
        // Timer that a truncated region decode would alias to
        access(1'b0, t % NT, 2, '0);
        access(1'b0, t % NT, 1, '0);
        access(1'b0, t % NT, 3, '0);
        report_test("3 error responder");

        t = int'(rand_bits(2));
        cmp = 4 + rand_bits(4);
        wait_cyc = 24 + int'(rand_bits(5));
        access(1'b1, t, 1, '0);
        access(1'b1, t, 2, cmp);
        access(1'b1, t, 0, 32'd1);
        repeat (wait_cyc) @(negedge clk_i);
        access(1'b1, t, 0, '0);
        // Wait covers more than one wrap
        m_pending[t] = 1'b1;
        access(1'b0, t, 1, '0);
        a = last_rdata;
        access(1'b0, t, 1, '0);
        b = last_rdata;
        check_true("count changed while the timer was disabled", a == b);
        check_true("count exceeded compare", a <= cmp);
        report_test("4 counting bound");

        for (int i = 0; i < NT; i++) begin
            access(1'b1, i, 1, '0);
            access(1'b1, i, 2, 1 + rand_bits(2));
        end
        access(1'b1, IRQ_R, 1, {NT{1'b1}});
        for (int i = 0; i < NT; i++) access(1'b1, i, 0, 32'd1);
        repeat (12) @(negedge clk_i);
        for (int i = 0; i < NT; i++) access(1'b1, i, 0, '0);
        m_pending = '1;
        check_true("irq_o not raised by pending timer events", irq_o == 1'b1);
        for (int i = 0; i <= NT; i++) access(1'b0, IRQ_R, 2, '0);
        check_true("irq_o still high after all claims", irq_o == 1'b0);
        report_test("5 interrupt and claim");

        access(1'b1, IRQ_R, 1, '0);
        access(1'b1, 2, 1, '0);
        access(1'b1, 2, 2, 32'd1);
        access(1'b1, 2, 0, 32'd1);
        repeat (6) @(negedge clk_i);
        access(1'b1, 2, 0, '0);
        m_pending[2] = 1'b1;
        repeat (2) @(negedge clk_i);
        check_true("irq_o high for a masked source", irq_o == 1'b0);
        access(1'b0, IRQ_R, 0, '0);
        access(1'b0, IRQ_R, 2, '0);
        access(1'b1, IRQ_R, 1, 32'h4);
        repeat (2) @(negedge clk_i);
        check_true("irq_o not raised after unmasking", irq_o == 1'b1);
        access(1'b0, IRQ_R, 2, '0);
        repeat (2) @(negedge clk_i);
        check_true("irq_o still high after the claim", irq_o == 1'b0);
        report_test("6 masking");

        n_fail = n_fail + UUT.i_assert.err_count;
        $display("Checks passed: %0d, failed: %0d", n_pass, n_fail);
        if (n_fail == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// File: periph_subsys_assert.sv
`timescale 1ns/100ps
`include "periph_cfg.svh"

module periph_subsys_assert
    import periph_pkg::*;
(
    input logic      clk_i,
    input logic      reset_i,
    input logic      req_valid_i,
    input logic      rsp_valid_o,
    input reg_data_t rsp_rdata_o,
    input logic      rsp_error_o,
    input logic      irq_o
);

    int err_count = 0;

    // ----------------------------------------
    // Register bus
    // ----------------------------------------
    req_gets_rsp: assert property (@(posedge clk_i) disable iff (reset_i)
        req_valid_i |=> rsp_valid_o)
    else begin
        err_count++;
        $error("request not answered one cycle later");
    end

    rsp_has_req: assert property (@(posedge clk_i) disable iff (reset_i)
        rsp_valid_o |-> $past(req_valid_i))
    else begin
        err_count++;
        $error("response without a request");
    end

    err_word: assert property (@(posedge clk_i) disable iff (reset_i)
        rsp_error_o |-> (rsp_rdata_o == `PERIPH_ERR_DATA))
    else begin
        err_count++;
        $error("error response with the wrong data word");
    end

    // Interrupt line cleared by reset
    irq_after_reset: assert property (@(posedge clk_i) $past(reset_i) |-> !irq_o)
    else begin
        err_count++;
        $error("irq_o high after reset");
    end

endmodule

bind periph_subsys periph_subsys_assert i_assert (.*);

// File: periph_subsys.sv
`timescale 1ns/100ps
`include "periph_cfg.svh"

module periph_subsys
    import periph_pkg::*;
(
    input  logic      clk_i,
    input  logic      reset_i,
    // Register bus request
    input  logic      req_valid_i,
    input  logic      req_write_i,
    input  reg_addr_t req_addr_i,
    input  reg_data_t req_wdata_i,
    // Register bus response
    output logic      rsp_valid_o,
    output reg_data_t rsp_rdata_o,
    output logic      rsp_error_o,
    // Interrupt to the core
    output logic      irq_o
);

    logic [`PERIPH_NUM_TIMERS-1:0] timer_sel;
    logic [`PERIPH_NUM_TIMERS-1:0] timer_match;
    reg_data_t                     timer_rdata [`PERIPH_NUM_TIMERS];
    logic                          irq_sel;
    reg_data_t                     irq_rdata;
    logic                          bus_write;
    reg_offset_t                   bus_offset;
    reg_data_t                     bus_wdata;

    // ----------------------------------------
    // Address decoder and error responder
    // ----------------------------------------
    periph_decoder i_decoder (
        .clk_i         ( clk_i       ),
        .reset_i       ( reset_i     ),
        .req_valid_i   ( req_valid_i ),
        .req_write_i   ( req_write_i ),
        .req_addr_i    ( req_addr_i  ),
        .req_wdata_i   ( req_wdata_i ),
        .timer_rdata_i ( timer_rdata ),
        .irq_rdata_i   ( irq_rdata   ),
        .timer_sel_o   ( timer_sel   ),
        .irq_sel_o     ( irq_sel     ),
        .write_o       ( bus_write   ),
        .offset_o      ( bus_offset  ),
        .wdata_o       ( bus_wdata   ),
        .rsp_valid_o   ( rsp_valid_o ),
        .rsp_rdata_o   ( rsp_rdata_o ),
        .rsp_error_o   ( rsp_error_o )
    );

    // ----------------------------------------
    // Timer channels
    // ----------------------------------------
    for (genvar i = 0; i < `PERIPH_NUM_TIMERS; i++) begin : gen_timer
        timer_unit i_timer (
            .clk_i    ( clk_i          ),
            .reset_i  ( reset_i        ),
            .sel_i    ( timer_sel[i]   ),
            .write_i  ( bus_write      ),
            .offset_i ( bus_offset     ),
            .wdata_i  ( bus_wdata      ),
            .rdata_o  ( timer_rdata[i] ),
            .match_o  ( timer_match[i] )
        );
    end

    // ----------------------------------------
    // Interrupt collector
    // ----------------------------------------
    irq_collector #(
        .NUM_SRC ( `PERIPH_NUM_TIMERS )
    ) i_irq_collector (
        .clk_i    ( clk_i       ),
        .reset_i  ( reset_i     ),
        .sel_i    ( irq_sel     ),
        .write_i  ( bus_write   ),
        .offset_i ( bus_offset  ),
        .wdata_i  ( bus_wdata   ),
        .src_i    ( timer_match ),
        .rdata_o  ( irq_rdata   ),
        .irq_o    ( irq_o       )
    );

endmodule

// File: irq_collector.sv
`timescale 1ns/100ps
`include "periph_cfg.svh"

module irq_collector
    import periph_pkg::*;
#(
    parameter int NUM_SRC = `PERIPH_NUM_TIMERS
) (
    input  logic               clk_i,
    input  logic               reset_i,
    input  logic               sel_i,
    input  logic               write_i,
    input  reg_offset_t        offset_i,
    input  reg_data_t          wdata_i,
    input  logic [NUM_SRC-1:0] src_i,
    output reg_data_t          rdata_o,
    output logic               irq_o
);

    logic [NUM_SRC-1:0] pending_q;
    logic [NUM_SRC-1:0] enable_q;
    logic [NUM_SRC-1:0] active;
    logic [NUM_SRC-1:0] claim_onehot;
    logic [NUM_SRC-1:0] claim_clr;
    src_id_t            claim_id;
    logic               claim_fire;

    assign active = pending_q & enable_q;

    // ----------------------------------------
    // Fixed priority claim
    // ----------------------------------------
    // Lowest index wins
    always_comb begin
        claim_id     = '0;
        claim_onehot = '0;
        for (int i = NUM_SRC - 1; i >= 0; i--) begin
            if (active[i]) begin
                claim_id        = src_id_t'(i + 1);
                claim_onehot    = '0;
                claim_onehot[i] = 1'b1;
            end
        end
    end

    assign claim_fire = sel_i && !write_i && (offset_i == IRQ_CLAIM);
    assign claim_clr  = claim_fire ? claim_onehot : '0;

    // ----------------------------------------
    // Pending and enable state
    // ----------------------------------------
    // New events are ORed in after the clear, so a same-cycle match survives
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            pending_q <= '0;
        end else begin
            pending_q <= (pending_q & ~claim_clr) | src_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            enable_q <= '0;
        end else if (sel_i && write_i && offset_i == IRQ_ENABLE) begin
            enable_q <= wdata_i[NUM_SRC-1:0];
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            irq_o <= 1'b0;
        end else begin
            irq_o <= |active;
        end
    end

    // ----------------------------------------
    // Read mux
    // ----------------------------------------
    always_comb begin
        case (offset_i)
            IRQ_PENDING: rdata_o = reg_data_t'(pending_q);
            IRQ_ENABLE:  rdata_o = reg_data_t'(enable_q);
            IRQ_CLAIM:   rdata_o = reg_data_t'(claim_id);
            default:     rdata_o = '0;
        endcase
    end

endmodule

// File: timer_unit.sv
`timescale 1ns/100ps

module timer_unit
    import periph_pkg::*;
(
    input  logic        clk_i,
    input  logic        reset_i,
    input  logic        sel_i,
    input  logic        write_i,
    input  reg_offset_t offset_i,
    input  reg_data_t   wdata_i,
    output reg_data_t   rdata_o,
    output logic        match_o
);

    logic      enable_q;
    reg_data_t count_q;
    reg_data_t compare_q;
    logic      wr_en;
    logic      at_compare;

    assign wr_en      = sel_i & write_i;
    assign at_compare = (count_q == compare_q);

    // ----------------------------------------
    // Registers
    // ----------------------------------------
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            enable_q  <= 1'b0;
            compare_q <= '0;
        end else if (wr_en) begin
            if (offset_i == TIMER_CTRL) begin
                enable_q <= wdata_i[0];
            end
            if (offset_i == TIMER_COMPARE) begin
                compare_q <= wdata_i;
            end
        end
    end

    // Software load wins over counting
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            count_q <= '0;
        end else if (wr_en && offset_i == TIMER_COUNT) begin
            count_q <= wdata_i;
        end else if (enable_q) begin
            count_q <= at_compare ? '0 : count_q + 1'b1;
        end
    end

    // One pulse per wrap
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            match_o <= 1'b0;
        end else begin
            match_o <= enable_q & at_compare;
        end
    end

    // ----------------------------------------
    // Read mux
    // ----------------------------------------
    always_comb begin
        case (offset_i)
            TIMER_CTRL:    rdata_o = reg_data_t'(enable_q);
            TIMER_COUNT:   rdata_o = count_q;
            TIMER_COMPARE: rdata_o = compare_q;
            default:       rdata_o = '0;
        endcase
    end

endmodule

// File: periph_decoder.sv
`timescale 1ns/100ps
`include "periph_cfg.svh"

module periph_decoder
    import periph_pkg::*;
(
    input  logic                          clk_i,
    input  logic                          reset_i,
    // Request side
    input  logic                          req_valid_i,
    input  logic                          req_write_i,
    input  reg_addr_t                     req_addr_i,
    input  reg_data_t                     req_wdata_i,
    // Read data from the targets
    input  reg_data_t                     timer_rdata_i [`PERIPH_NUM_TIMERS],
    input  reg_data_t                     irq_rdata_i,
    // Strobes towards the targets
    output logic [`PERIPH_NUM_TIMERS-1:0] timer_sel_o,
    output logic                          irq_sel_o,
    output logic                          write_o,
    output reg_offset_t                   offset_o,
    output reg_data_t                     wdata_o,
    // Response side
    output logic                          rsp_valid_o,
    output reg_data_t                     rsp_rdata_o,
    output logic                          rsp_error_o
);

    region_t                       region;
    logic [`PERIPH_NUM_TIMERS-1:0] timer_hit;
    logic                          irq_hit;
    logic                          map_err;
    reg_data_t                     rd_mux;
    reg_data_t                     rsp_rdata_d;

    // ----------------------------------------
    // Address decode
    // ----------------------------------------
    assign region   = req_addr_i[`PERIPH_REGION_LSB +: $bits(region_t)];
    assign offset_o = req_addr_i[3:2];
    assign write_o  = req_write_i;
    assign wdata_o  = req_wdata_i;

    always_comb begin
        for (int i = 0; i < `PERIPH_NUM_TIMERS; i++) begin
            timer_hit[i] = (region == region_t'(i));
        end
    end

    assign irq_hit = (region == region_t'(`PERIPH_IRQ_REGION));
    // Nothing mapped here, the error responder answers
    assign map_err = !((|timer_hit) || irq_hit);

    assign timer_sel_o = timer_hit & {`PERIPH_NUM_TIMERS{req_valid_i}};
    assign irq_sel_o   = irq_hit & req_valid_i;

    // ----------------------------------------
    // Response
    // ----------------------------------------
    always_comb begin
        rd_mux = irq_hit ? irq_rdata_i : '0;
        for (int i = 0; i < `PERIPH_NUM_TIMERS; i++) begin
            if (timer_hit[i]) begin
                rd_mux = timer_rdata_i[i];
            end
        end
    end

    always_comb begin
        if (map_err) begin
            rsp_rdata_d = `PERIPH_ERR_DATA;
        end else if (req_write_i) begin
            rsp_rdata_d = '0;
        end else begin
            rsp_rdata_d = rd_mux;
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            rsp_valid_o <= 1'b0;
            rsp_error_o <= 1'b0;
        end else begin
            rsp_valid_o <= req_valid_i;
            rsp_error_o <= req_valid_i & map_err;
        end
    end

    always_ff @(posedge clk_i) begin
        if (req_valid_i) begin
            rsp_rdata_o <= rsp_rdata_d;
        end
    end

endmodule

// File: periph_pkg.sv
package periph_pkg;

    `include "periph_cfg.svh"

    // ----------------------------------------
    // Register bus types
    // ----------------------------------------
    typedef logic [`PERIPH_ADDR_W-1:0] reg_addr_t;
    typedef logic [`PERIPH_DATA_W-1:0] reg_data_t;

    typedef logic [3:0] region_t;
    // Word offset from addr[3:2]
    typedef logic [1:0] reg_offset_t;

    // Claim id, 0 is none and k+1 is source k; covers up to 15 sources
    typedef logic [3:0] src_id_t;

    // ----------------------------------------
    // Register offsets
    // ----------------------------------------
    typedef enum logic [1:0] {
        TIMER_CTRL    = 2'd0,
        TIMER_COUNT   = 2'd1,
        TIMER_COMPARE = 2'd2
    } timer_reg_e;

    typedef enum logic [1:0] {
        IRQ_PENDING = 2'd0,
        IRQ_ENABLE  = 2'd1,
        IRQ_CLAIM   = 2'd2
    } irq_reg_e;

endpackage

// File: periph_cfg.svh
`ifndef PERIPH_CFG_SVH
`define PERIPH_CFG_SVH

// ----------------------------------------
// Subsystem sizing
// ----------------------------------------
`define PERIPH_NUM_TIMERS 4

// Register bus widths
`define PERIPH_DATA_W 32
`define PERIPH_ADDR_W 16

// ----------------------------------------
// Address map
// ----------------------------------------
// Region field is addr[REGION_LSB +: 4]
`define PERIPH_REGION_LSB 8
`define PERIPH_IRQ_REGION 15

// Data word of an error response
`define PERIPH_ERR_DATA 32'hdeadbeef

`endif
